//--- flist.f
+incdir+.
prefetch_pkg.sv
fetch_dispatch.sv
block_fetch.sv
bus_arbiter.sv
prefetch_top.sv
prefetch_chk.sv
prefetch_tb.sv

//--- prefetch_tb.sv
`timescale 1ns/10ps
`include "prefetch_macros.svh"

module prefetch_tb;
   import prefetch_pkg::*;

   // sixteen blocks in all, each word allowed a generous worst case of ack latency and stalls.
   localparam int NUM_BLOCKS  = 16;
   localparam int WORD_CYCLES = 12;
   localparam int CYCLE_LIMIT = NUM_BLOCKS * `PF_BLK_WORDS * WORD_CYCLES + 500;

   logic                       clk_i = 1'b0;
   logic                       rst_i;
   logic                       req_i;
   logic [`PF_BLKNUM_BITS-1:0] blk_num_i;
   logic                       busy_o;
   wb_req_t                    bus_req_o;
   wb_rsp_t                    bus_rsp_i;
   pf_word_t                   word_o;
   pf_done_t                   done_o;

   // memory model: accepted addresses wait in order with the cycle their ack is due.
   logic [`PF_ADDR_BITS-1:0]   adr_q[$];
   int                         due_q[$];
   logic                       stall_en;
   logic                       err_armed;
   logic [`PF_ADDR_BITS-1:0]   err_addr;
   wb_rsp_t                    rsp;
   int                         lat;

   // expected state of every channel, following the lowest-idle-first rule.
   logic [`PF_CHANNELS-1:0]    model_active;
   logic [`PF_CHANNELS-1:0]    done_pend;
   logic [`PF_BLKNUM_BITS-1:0] chan_blk[`PF_CHANNELS];
   int                         got_cnt[`PF_CHANNELS];
   int                         exp_words[`PF_CHANNELS];
   logic                       exp_err[`PF_CHANNELS];
   int                         sel;
   int                         ch;
   logic [`PF_IDX_BITS-1:0]    widx;
   logic                       burst_open = 1'b0;
   int                         burst_chan = 0;
   int                         last_start_chan = -1;
   int                         last_done_chan = -1;
   int                         err_chan;

   int                         cycles = 0;
   int                         errors = 0;
   int                         done_cnt = 0;
   int                         err_done_cnt = 0;
   int                         tests_run = 0;
   int                         tests_failed = 0;
   int                         base_errors;
   int                         base_done;
   int                         base_err_done;
   string                      cur_test;

   prefetch_top prefetch_top_inst (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .req_i     (req_i),
      .blk_num_i (blk_num_i),
      .busy_o    (busy_o),
      .bus_req_o (bus_req_o),
      .bus_rsp_i (bus_rsp_i),
      .word_o    (word_o),
      .done_o    (done_o)
   );

   always #2 clk_i = ~clk_i;

   // the run is cut off once the cycle budget of all tests is spent.
   always @(posedge clk_i) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // memory contents, a fixed mix of the word address bits.
   function automatic logic [`PF_DATA_BITS-1:0] ref_data(input logic [`PF_ADDR_BITS-1:0] adr);
      return {adr, adr ^ 16'ha5c3} + {8'h00, adr[11:0], adr[15:4]};
   endfunction

   task automatic check_equal(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act) begin
         $display("error: %s: %s expected %h actual %h", cur_test, what, exp, act);
         errors++;
      end
   endtask

   // the response for the coming rising edge is decided on the falling edge.
   // an error replaces the ack of its address and drops every later address.
   always @(negedge clk_i) begin
      rsp = '0;
      if (rst_i) begin
         adr_q.delete();
         due_q.delete();
      end else begin
         if (adr_q.size() > 0 && due_q[0] <= cycles) begin
            if (err_armed && adr_q[0] == err_addr) begin
               rsp.err = 1'b1;
               rsp.wat = 1'b1;
               adr_q.delete();
               due_q.delete();
            end else begin
               rsp.ack = 1'b1;
               rsp.dat = ref_data(adr_q.pop_front());
               void'(due_q.pop_front());
            end
         end
         if (!rsp.err) begin
            rsp.wat = stall_en && ($urandom_range(3, 0) == 0);
         end
         if (bus_req_o.stb && !rsp.wat) begin
            // every address but the last word of a block announces that more follow.
            check_equal("burst flag",
                        bus_req_o.adr.flat[`PF_IDX_BITS-1:0] != `PF_BLK_WORDS - 1,
                        bus_req_o.bst);
            lat = stall_en ? $urandom_range(3, 1) : 1;
            adr_q.push_back(bus_req_o.adr.flat);
            due_q.push_back(cycles + lat);
         end
      end
      bus_rsp_i = rsp;
   end

   // a request takes the lowest channel that was idle before this edge.
   // a done seen in the last cycle frees its channel at this same edge.
   always @(posedge clk_i) begin
      if (rst_i) begin
         model_active = '0;
         done_pend    = '0;
      end else begin
         sel = -1;
         for (int c = 0; c < `PF_CHANNELS; c++) begin
            if (sel < 0 && !model_active[c]) begin
               sel = c;
            end
         end
         model_active = model_active & ~done_pend;
         done_pend    = '0;
         if (req_i && sel >= 0) begin
            model_active[sel] = 1'b1;
            chan_blk[sel]     = blk_num_i;
            got_cnt[sel]      = 0;
            exp_err[sel]      = err_armed && (err_addr[15:4] == blk_num_i);
            exp_words[sel]    = exp_err[sel] ? int'(err_addr[3:0]) : `PF_BLK_WORDS;
            last_start_chan   = sel;
         end
      end
   end

   // outputs are registered, so they are compared on the falling edge.
   always @(negedge clk_i) begin
      if (!rst_i && word_o.valid) begin
         ch = word_o.chan;
         if (!model_active[ch] || got_cnt[ch] >= exp_words[ch]) begin
            $display("error: %s: word on channel %0d outside its block", cur_test, ch);
            errors++;
         end else begin
            if (burst_open && burst_chan != ch) begin
               $display("error: %s: channel %0d interleaved a burst", cur_test, ch);
               errors++;
            end
            widx = got_cnt[ch];
            check_equal("word index", widx, word_o.idx);
            check_equal("word data", ref_data({chan_blk[ch], widx}), word_o.data);
            got_cnt[ch]++;
            burst_open = 1'b1;
            burst_chan = ch;
         end
      end
      if (!rst_i && done_o.valid) begin
         ch = done_o.chan;
         if (!model_active[ch]) begin
            $display("error: %s: done on idle channel %0d", cur_test, ch);
            errors++;
         end
         check_equal("done word count", exp_words[ch], got_cnt[ch]);
         check_equal("done error flag", exp_err[ch], done_o.err);
         done_cnt++;
         if (done_o.err) begin
            err_done_cnt++;
         end
         done_pend[ch]  = 1'b1;
         last_done_chan = ch;
         burst_open     = 1'b0;
      end
   end

   task automatic start_test(input string name);
      cur_test      = name;
      base_errors   = errors;
      base_done     = done_cnt;
      base_err_done = err_done_cnt;
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors == base_errors) begin
         $display("test %s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", cur_test, errors - base_errors);
      end
   endtask

   // starts at a falling edge and leaves req low at the next one.
   task automatic send_block(input logic [`PF_BLKNUM_BITS-1:0] blk);
      while (busy_o) begin
         @(negedge clk_i);
      end
      req_i     = 1'b1;
      blk_num_i = blk;
      @(negedge clk_i);
      req_i = 1'b0;
   endtask

   task automatic pulse_while_busy(input logic [`PF_BLKNUM_BITS-1:0] blk);
      check_equal("busy with every channel active", 1, busy_o);
      req_i     = 1'b1;
      blk_num_i = blk;
      @(negedge clk_i);
      req_i = 1'b0;
   endtask

   task automatic wait_idle();
      @(negedge clk_i);
      while (model_active != '0 || done_pend != '0 || adr_q.size() != 0) begin
         @(negedge clk_i);
      end
      repeat (3) @(negedge clk_i);
   endtask

   task automatic check_idle_outputs();
      check_equal("busy", 0, busy_o);
      check_equal("bus cyc", 0, bus_req_o.cyc);
      check_equal("word valid", 0, word_o.valid);
      check_equal("done valid", 0, done_o.valid);
   endtask

   initial begin
      void'($urandom(32'h2ee94bdd));
      rst_i     = 1'b1;
      req_i     = 1'b0;
      blk_num_i = '0;
      bus_rsp_i = '0;
      stall_en  = 1'b0;
      err_armed = 1'b0;
      err_addr  = '0;

      start_test("reset");
      repeat (4) begin
         @(negedge clk_i);
         check_idle_outputs();
      end
      rst_i = 1'b0;
      repeat (4) begin
         @(negedge clk_i);
         check_idle_outputs();
      end
      finish_test();

      start_test("one_block");
      send_block(12'h010);
      wait_idle();
      check_equal("blocks done", 1, done_cnt - base_done);
      check_equal("error dones", 0, err_done_cnt - base_err_done);
      finish_test();

      start_test("four_channels");
      for (int i = 0; i < 4; i++) begin
         send_block(12'h100 + i);
      end
      pulse_while_busy(12'h1ff);
      wait_idle();
      check_equal("blocks done", 4, done_cnt - base_done);
      finish_test();

      // random stalls and ack latency stay on from here.
      start_test("stalls");
      stall_en = 1'b1;
      for (int i = 0; i < 4; i++) begin
         send_block($urandom_range(12'hfff, 0));
      end
      wait_idle();
      check_equal("blocks done", 4, done_cnt - base_done);
      finish_test();

      start_test("bus_error");
      err_armed = 1'b1;
      err_addr  = {12'h0a5, 4'd5};
      send_block(12'h0a5);
      wait_idle();
      err_armed = 1'b0;
      err_chan  = last_done_chan;
      send_block(12'h0a6);
      check_equal("channel after error", err_chan, last_start_chan);
      wait_idle();
      check_equal("blocks done", 2, done_cnt - base_done);
      check_equal("error dones", 1, err_done_cnt - base_err_done);
      finish_test();

      start_test("reuse_freed");
      for (int i = 0; i < 4; i++) begin
         send_block(12'h200 + i);
      end
      pulse_while_busy(12'h2ff);
      while (busy_o) begin
         @(negedge clk_i);
      end
      send_block(12'h2aa);
      // the one freed channel took the block, so every channel is active again.
      check_equal("busy after refill", 1, busy_o);
      wait_idle();
      check_equal("blocks done", 5, done_cnt - base_done);
      finish_test();

      errors += prefetch_top_inst.prefetch_chk_inst.fail_cnt;
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- prefetch_chk.sv
`timescale 1ns/10ps
`include "prefetch_macros.svh"

module prefetch_chk (
   input logic                                     clk_i,
   input logic                                     rst_i,
   input logic                                     busy_i,
   input logic [`PF_CHANNELS-1:0]                  start_i,
   input prefetch_pkg::wb_req_t [`PF_CHANNELS-1:0] ch_req_i,
   input logic [`PF_CHANNELS-1:0]                  ch_done_i,
   input prefetch_pkg::wb_req_t                    bus_req_i,
   input prefetch_pkg::wb_rsp_t                    bus_rsp_i,
   input prefetch_pkg::pf_word_t                   word_i,
   input prefetch_pkg::pf_done_t                   done_i
);

   int unsigned fail_cnt = 0;

   // a channel is in use from its start pulse, through its bus cycle and its
   // own done, until the registered done leaves the arbiter.
   logic [`PF_CHANNELS-1:0] in_use;

   always_comb begin
      for (int i = 0; i < `PF_CHANNELS; i++) begin
         in_use[i] = start_i[i] || ch_req_i[i].cyc || ch_done_i[i] ||
                     (done_i.valid && (done_i.chan == i));
      end
   end

   // an address strobe is only valid inside an open bus cycle.
   a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      bus_req_i.stb |-> bus_req_i.cyc)
   else begin
      $error("bus strobe raised outside a bus cycle");
      fail_cnt++;
   end

   // each output beat follows an ack that came while the bus cycle was still open.
   a_word_after_ack: assert property (@(posedge clk_i) disable iff (rst_i)
      word_i.valid |-> $past(bus_rsp_i.ack && bus_req_i.cyc))
   else begin
      $error("output word without an ack inside a bus cycle before it");
      fail_cnt++;
   end

   // busy means that no channel is left for a new block.
   a_busy_full: assert property (@(posedge clk_i) disable iff (rst_i)
      busy_i |-> (&in_use))
   else begin
      $error("busy raised while a channel was idle");
      fail_cnt++;
   end

endmodule

bind prefetch_top prefetch_chk prefetch_chk_inst (
   .clk_i     (clk_i),
   .rst_i     (rst_i),
   .busy_i    (busy_o),
   .start_i   (start),
   .ch_req_i  (ch_req),
   .ch_done_i (ch_done),
   .bus_req_i (bus_req_o),
   .bus_rsp_i (bus_rsp_i),
   .word_i    (word_o),
   .done_i    (done_o)
);

//--- prefetch_top.sv
`timescale 1ns/10ps
`include "prefetch_macros.svh"

module prefetch_top (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       req_i,
   input  logic [`PF_BLKNUM_BITS-1:0] blk_num_i,
   output logic                       busy_o,
   output prefetch_pkg::wb_req_t      bus_req_o,
   input  prefetch_pkg::wb_rsp_t      bus_rsp_i,
   output prefetch_pkg::pf_word_t     word_o,
   output prefetch_pkg::pf_done_t     done_o
);
   import prefetch_pkg::*;

   // start pulses and the shared block number from the dispatcher.
   logic [`PF_CHANNELS-1:0]       start;
   logic [`PF_BLKNUM_BITS-1:0]    blk_num;

   // per-channel bus ports between the fetchers and the arbiter.
   wb_req_t [`PF_CHANNELS-1:0]    ch_req;
   wb_rsp_t [`PF_CHANNELS-1:0]    ch_rsp;
   logic [`PF_CHANNELS-1:0]       ch_done;
   logic [`PF_CHANNELS-1:0]       ch_err;

   // the registered done from the arbiter frees the channel for reuse.
   fetch_dispatch u_dispatch (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .req_i     (req_i),
      .blk_num_i (blk_num_i),
      .done_i    (done_o),
      .start_o   (start),
      .blk_num_o (blk_num),
      .busy_o    (busy_o)
   );

   for (genvar i = 0; i < `PF_CHANNELS; i++) begin : g_chan
      block_fetch u_fetch (
         .clk_i     (clk_i),
         .rst_i     (rst_i),
         .start_i   (start[i]),
         .blk_num_i (blk_num),
         .req_o     (ch_req[i]),
         .rsp_i     (ch_rsp[i]),
         .done_o    (ch_done[i]),
         .err_o     (ch_err[i])
      );
   end

   bus_arbiter u_arbiter (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .req_i     (ch_req),
      .rsp_o     (ch_rsp),
      .done_i    (ch_done),
      .err_i     (ch_err),
      .bus_req_o (bus_req_o),
      .bus_rsp_i (bus_rsp_i),
      .word_o    (word_o),
      .done_o    (done_o)
   );

endmodule

//--- bus_arbiter.sv
`timescale 1ns/10ps
`include "prefetch_macros.svh"

module bus_arbiter (
   input  logic                                      clk_i,
   input  logic                                      rst_i,
   input  prefetch_pkg::wb_req_t [`PF_CHANNELS-1:0]  req_i,
   output prefetch_pkg::wb_rsp_t [`PF_CHANNELS-1:0]  rsp_o,
   input  logic [`PF_CHANNELS-1:0]                   done_i,
   input  logic [`PF_CHANNELS-1:0]                   err_i,
   output prefetch_pkg::wb_req_t                     bus_req_o,
   input  prefetch_pkg::wb_rsp_t                     bus_rsp_i,
   output prefetch_pkg::pf_word_t                    word_o,
   output prefetch_pkg::pf_done_t                    done_o
);
   import prefetch_pkg::*;

   // the bus is owned when gnt_q is high, by the channel in owner_q.
   // owner_q keeps the last owner while idle, as the round-robin origin.
   logic                       gnt_q;
   logic [`PF_CHAN_BITS-1:0]   owner_q;

   logic                       release_bus;
   logic                       found;
   logic [`PF_CHAN_BITS-1:0]   pick;
   logic [`PF_CHAN_BITS-1:0]   cand;

   // words returned to the current owner so far.
   logic [`PF_IDX_BITS-1:0]    cnt_q;

   logic [`PF_CHAN_BITS-1:0]   done_chan;
   wb_rsp_t                    masked;

   logic                       word_vld_q;
   logic [`PF_CHAN_BITS-1:0]   word_chan_q;
   logic [`PF_IDX_BITS-1:0]    word_idx_q;
   logic [`PF_DATA_BITS-1:0]   word_dat_q;

   logic                       done_vld_q;
   logic [`PF_CHAN_BITS-1:0]   done_chan_q;
   logic                       done_err_q;

   // the grant is open for a new owner when the bus is idle
   // or the owner has dropped its cycle.
   assign release_bus = !gnt_q || !req_i[owner_q].cyc;

   // search starts one past the last owner and wraps round to it.
   always_comb begin
      pick  = owner_q;
      found = 1'b0;
      cand  = owner_q;
      for (int unsigned off = 1; off <= `PF_CHANNELS; off++) begin
         cand = owner_q + off[`PF_CHAN_BITS-1:0];
         if (!found && req_i[cand].cyc) begin
            pick  = cand;
            found = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         gnt_q   <= 1'b0;
         owner_q <= '1;
         cnt_q   <= '0;
      end else if (release_bus) begin
         gnt_q <= found;
         if (found) begin
            owner_q <= pick;
         end
         cnt_q <= '0;
      end else if (bus_rsp_i.ack) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // the owner drives the bus directly; an idle bus shows all levels low.
   assign bus_req_o = gnt_q ? req_i[owner_q] : '0;

   // channels without the grant see a stall and never an ack or an error.
   always_comb begin
      masked     = bus_rsp_i;
      masked.ack = 1'b0;
      masked.wat = 1'b1;
      masked.err = 1'b0;
      for (int i = 0; i < `PF_CHANNELS; i++) begin
         rsp_o[i] = (gnt_q && (owner_q == i)) ? bus_rsp_i : masked;
      end
   end

   // only the bus owner can finish, so at most one done bit is set.
   always_comb begin
      done_chan = '0;
      for (int i = 0; i < `PF_CHANNELS; i++) begin
         if (done_i[i]) begin
            done_chan = i[`PF_CHAN_BITS-1:0];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         word_vld_q <= 1'b0;
         done_vld_q <= 1'b0;
      end else begin
         word_vld_q <= gnt_q && bus_rsp_i.ack;
         done_vld_q <= |done_i;
      end
   end

   always_ff @(posedge clk_i) begin
      word_chan_q <= owner_q;
      word_idx_q  <= cnt_q;
      word_dat_q  <= bus_rsp_i.dat;
      done_chan_q <= done_chan;
      done_err_q  <= |(done_i & err_i);
   end

   assign word_o.valid = word_vld_q;
   assign word_o.chan  = word_chan_q;
   assign word_o.idx   = word_idx_q;
   assign word_o.data  = word_dat_q;

   assign done_o.valid = done_vld_q;
   assign done_o.chan  = done_chan_q;
   assign done_o.err   = done_err_q;

endmodule

//--- block_fetch.sv
`timescale 1ns/10ps
`include "prefetch_macros.svh"

module block_fetch (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       start_i,
   input  logic [`PF_BLKNUM_BITS-1:0] blk_num_i,
   output prefetch_pkg::wb_req_t      req_o,
   input  prefetch_pkg::wb_rsp_t      rsp_i,
   output logic                       done_o,
   output logic                       err_o
);
   import prefetch_pkg::*;

   // bus control levels, loaded together on start.
   logic                       cyc_q;
   logic                       stb_q;
   logic                       bst_q;

   // index of the next address to put on the bus.
   logic [`PF_IDX_BITS-1:0]    idx_q;
   logic [`PF_BLKNUM_BITS-1:0] blk_q;

   // addresses accepted but not yet acknowledged.
   logic [`PF_WAT_BITS-1:0]    wat_q;
   logic [`PF_WAT_BITS-1:0]    wat_nxt;

   logic                       stb_out;
   logic                       accept;
   logic                       stb_nxt;
   logic                       cyc_nxt;
   pf_addr_u                   adr;

   // the strobe is held back while the outstanding count is full,
   // so the count can never wrap.
   assign stb_out = stb_q && !(&wat_q);

   // an address is taken when it is strobed and the bus does not wait.
   assign accept  = cyc_q && stb_out && !rsp_i.wat;

   // the last address is the one taken while bst is already low.
   assign stb_nxt = stb_q && !(accept && !bst_q);

   always_comb begin
      case ({accept, cyc_q && rsp_i.ack})
         2'b10:   wat_nxt = wat_q + 1'b1;
         2'b01:   wat_nxt = wat_q - 1'b1;
         default: wat_nxt = wat_q;
      endcase
   end

   // the cycle stays open while addresses remain or acks are still due.
   // an error closes it at once.
   assign cyc_nxt = !rsp_i.err && (stb_nxt || (wat_nxt != '0));

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cyc_q  <= 1'b0;
         stb_q  <= 1'b0;
         bst_q  <= 1'b0;
         idx_q  <= '0;
         wat_q  <= '0;
         done_o <= 1'b0;
         err_o  <= 1'b0;
      end else if (start_i) begin
         cyc_q  <= 1'b1;
         stb_q  <= 1'b1;
         bst_q  <= 1'b1;
         idx_q  <= '0;
         wat_q  <= '0;
         done_o <= 1'b0;
         err_o  <= 1'b0;
      end else if (cyc_q) begin
         cyc_q <= cyc_nxt;
         stb_q <= stb_nxt && cyc_nxt;
         // bst drops when the address about to go out is the last one.
         if (!cyc_nxt) begin
            bst_q <= 1'b0;
         end else if (accept) begin
            bst_q <= (idx_q < (`PF_BLK_WORDS - 2));
         end
         if (accept) begin
            idx_q <= idx_q + 1'b1;
         end
         wat_q  <= cyc_nxt ? wat_nxt : '0;
         // done pulses in the cycle after the last ack or the error.
         done_o <= !cyc_nxt;
         err_o  <= rsp_i.err;
      end else begin
         done_o <= 1'b0;
         err_o  <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         blk_q <= blk_num_i;
      end
   end

   // the address is written through its block view.
   always_comb begin
      adr.blk.blk = blk_q;
      adr.blk.idx = idx_q;
   end

   assign req_o.cyc = cyc_q;
   assign req_o.stb = stb_out;
   assign req_o.bst = bst_q;
   assign req_o.adr = adr;

endmodule

//--- fetch_dispatch.sv
`timescale 1ns/10ps
`include "prefetch_macros.svh"

module fetch_dispatch (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       req_i,
   input  logic [`PF_BLKNUM_BITS-1:0] blk_num_i,
   input  prefetch_pkg::pf_done_t     done_i,
   output logic [`PF_CHANNELS-1:0]    start_o,
   output logic [`PF_BLKNUM_BITS-1:0] blk_num_o,
   output logic                       busy_o
);

   // one bit per channel, set from start until its done comes back.
   logic [`PF_CHANNELS-1:0] active_q;

   // one-hot pick of the lowest idle channel.
   logic [`PF_CHANNELS-1:0] sel;
   logic                    found;

   // one-hot channel named by the incoming done.
   logic [`PF_CHANNELS-1:0] clr;

   logic                    accept;

   // scan upwards and keep the first idle channel.
   always_comb begin
      sel   = '0;
      found = 1'b0;
      for (int i = 0; i < `PF_CHANNELS; i++) begin
         if (!found && !active_q[i]) begin
            sel[i] = 1'b1;
            found  = 1'b1;
         end
      end
   end

   // a request is only taken when some channel is free.
   // a pulse while every channel is busy falls on the floor.
   assign accept = req_i && found;

   always_comb begin
      clr = '0;
      if (done_i.valid) begin
         clr[done_i.chan] = 1'b1;
      end
   end

   // busy follows the registered active bits, so it moves one cycle
   // after a start or a done.
   assign busy_o = &active_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         active_q <= '0;
         start_o  <= '0;
      end else begin
         active_q <= (active_q & ~clr) | (accept ? sel : '0);
         start_o  <= accept ? sel : '0;
      end
   end

   // the block number rides beside the start pulse on a shared bus.
   // only the started channel latches it.
   always_ff @(posedge clk_i) begin
      if (accept) begin
         blk_num_o <= blk_num_i;
      end
   end

endmodule

//--- prefetch_pkg.sv
`include "prefetch_macros.svh"

package prefetch_pkg;

   // a word address seen as a block number and an index within the block.
   // the block number sits in the upper bits, so the two views line up.
   typedef struct packed {
      logic [`PF_BLKNUM_BITS-1:0] blk;
      logic [`PF_IDX_BITS-1:0]    idx;
   } pf_blk_addr_t;

   // the external bus reads the flat view.
   // the fetchers and the output logic use the block view.
   typedef union packed {
      logic [`PF_ADDR_BITS-1:0] flat;
      pf_blk_addr_t             blk;
   } pf_addr_u;

   // request levels of one bus master.
   // bst stays high while more addresses follow the current one.
   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     bst;
      pf_addr_u adr;
   } wb_req_t;

   // response to one bus master.
   // wat high means the address on the bus is not taken this cycle.
   typedef struct packed {
      logic                     ack;
      logic                     wat;
      logic                     err;
      logic [`PF_DATA_BITS-1:0] dat;
   } wb_rsp_t;

   // one returned word, tagged with the channel that fetched it.
   typedef struct packed {
      logic                     valid;
      logic [`PF_CHAN_BITS-1:0] chan;
      logic [`PF_IDX_BITS-1:0]  idx;
      logic [`PF_DATA_BITS-1:0] data;
   } pf_word_t;

   // end of one block on a channel.
   // err is set when the burst was cut short by a bus error.
   typedef struct packed {
      logic                     valid;
      logic [`PF_CHAN_BITS-1:0] chan;
      logic                     err;
   } pf_done_t;

endpackage

//--- prefetch_macros.svh
`ifndef PREFETCH_MACROS_SVH
`define PREFETCH_MACROS_SVH

// sizes shared by every block of the prefetcher.
// the channel count and the block size move together, so they all live here.

// number of fetch channels and the width of a channel number.
`define PF_CHANNELS     4
`define PF_CHAN_BITS    2

// words in one block and the width of a word index inside a block.
`define PF_BLK_WORDS    16
`define PF_IDX_BITS     4

// a word address is a block number followed by a word index.
`define PF_BLKNUM_BITS  12
`define PF_ADDR_BITS    (`PF_BLKNUM_BITS + `PF_IDX_BITS)

// width of one data word on the bus.
`define PF_DATA_BITS    32

// width of the count of addresses still waiting for their ack.
`define PF_WAT_BITS     3

`endif
